/* Bender.yml */
package:
  name: replica

sources:
  - files:
      - replica_pkg.sv
      - replica_ctrl.sv
      - replica_order.sv
      - replica_stage.sv
      - replica_top.sv
  - target: test
    files:
      - replica_tb.sv

/* project.f */
replica_pkg.sv
replica_ctrl.sv
replica_order.sv
replica_stage.sv
replica_top.sv
replica_tb.sv

/* replica_ctrl.sv */
`default_nettype none

module replica_ctrl (
    input  logic                          clk,
    input  logic                          reset,
    input  replica_pkg::replica_command_t command,
    input  logic                          in_valid,
    input  replica_pkg::replica_word_t    in_data,
    output logic                          aligned_valid,
    output replica_pkg::replica_word_t    aligned_data,
    output replica_pkg::replica_command_t command_q,
    output logic                          phase
);

    logic                       in_valid_d1;
    logic                       in_valid_d2;
    logic                       in_valid_d3;
    replica_pkg::replica_word_t in_data_d1;
    replica_pkg::replica_word_t in_data_d2;
    replica_pkg::replica_word_t in_data_d3;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_valid_d1 <= 1'b0;
            in_valid_d2 <= 1'b0;
            in_valid_d3 <= 1'b0;
            command_q   <= replica_pkg::cmd_none;
            phase       <= 1'b0;
        end else begin
            in_valid_d1 <= in_valid;
            in_valid_d2 <= in_valid_d1;
            in_valid_d3 <= in_valid_d2;
            command_q   <= command;
            // every command that does something flips the exchange phase
            if (command != replica_pkg::cmd_none) begin
                phase <= ~phase;
            end
        end
    end

    // lanes are reversed on entry so that port lane 7 becomes internal lane 0
    always_ff @(posedge clk) begin
        for (int i = 0; i < replica_pkg::lanes; i++) begin
            in_data_d1[i] <= in_data[replica_pkg::lanes-1-i];
        end
        in_data_d2 <= in_data_d1;
        in_data_d3 <= in_data_d2;
    end

    assign aligned_valid = in_valid_d3;
    assign aligned_data  = in_data_d3;

    // a push and a command would both drive the stage registers in one cycle
    a_no_command_during_push: assert property (
        @(posedge clk) disable iff (reset)
        !(aligned_valid && (command_q != replica_pkg::cmd_none))
    ) else $error("command acts in a cycle with an aligned push");

endmodule

`default_nettype wire

/* replica_order.sv */
`default_nettype none

module replica_order (
    input  replica_pkg::opt_mode_t     mode,
    input  replica_pkg::opt_u          opt,
    input  replica_pkg::replica_word_t low_data,
    input  replica_pkg::replica_word_t high_data,
    output logic                       trade
);

    logic [replica_pkg::lane_w-1:0]   low_primary;
    logic [replica_pkg::lane_w-1:0]   high_primary;
    logic [replica_pkg::lane_w-1:0]   low_secondary;
    logic [replica_pkg::lane_w-1:0]   high_secondary;
    logic                             keyed_trade;
    logic [replica_pkg::lane_w-1:0]   lane0_diff;
    logic                             threshold_trade;

    // only the low three bits of each key field address a lane
    assign low_primary    = low_data[opt.keys.primary[2:0]];
    assign high_primary   = high_data[opt.keys.primary[2:0]];
    assign low_secondary  = low_data[opt.keys.secondary[2:0]];
    assign high_secondary = high_data[opt.keys.secondary[2:0]];

    // the lower stage holding the larger record gives ascending order toward the tail
    assign keyed_trade = (low_primary > high_primary) ||
                         ((low_primary == high_primary) && (low_secondary > high_secondary));

    assign lane0_diff = low_data[0] - high_data[0];

    // a negative difference never exceeds an unsigned threshold
    assign threshold_trade = (low_data[0] > high_data[0]) &&
                             ({{replica_pkg::lane_w{1'b0}}, lane0_diff} > opt.threshold);

    always_comb begin
        case (mode)
            replica_pkg::opt_threshold: trade = threshold_trade;
            default:                    trade = keyed_trade;
        endcase
    end

endmodule

`default_nettype wire

/* replica_pkg.sv */
`default_nettype none

package replica_pkg;

    // one lane of a replica record and the number of lanes per record
    localparam int lane_w = 7;
    localparam int lanes  = 8;

    // lane 0 sits in the low bits
    typedef logic [lanes-1:0][lane_w-1:0] replica_word_t;

    typedef enum logic [1:0] {
        cmd_none     = 2'd0,
        cmd_exchange = 2'd1,
        cmd_drain    = 2'd2,
        cmd_clear    = 2'd3
    } replica_command_t;

    // codes 2 and 3 are not named and fall back to keyed ordering
    typedef enum logic [1:0] {
        opt_keyed     = 2'd0,
        opt_threshold = 2'd1
    } opt_mode_t;

    // the same 14-bit option word is read as two lane keys or as one threshold
    typedef union packed {
        struct packed {
            logic [lane_w-1:0] primary;
            logic [lane_w-1:0] secondary;
        } keys;
        logic [2*lane_w-1:0] threshold;
    } opt_u;

endpackage

`default_nettype wire

/* replica_stage.sv */
`default_nettype none

module replica_stage #(
    parameter int n_stages = 8,
    parameter int index    = 0
) (
    input  logic                          clk,
    input  logic                          reset,
    input  replica_pkg::replica_command_t command,
    input  replica_pkg::opt_mode_t        mode,
    input  replica_pkg::opt_u             opt,
    input  logic                          phase,
    input  logic                          shift_valid,
    input  logic                          prev_valid,
    input  replica_pkg::replica_word_t    prev_data,
    input  logic                          folw_valid,
    input  replica_pkg::replica_word_t    folw_data,
    output logic                          out_valid,
    output replica_pkg::replica_word_t    out_data
);

    // neighbours that exist for this position in the chain
    localparam bit has_prev  = (index > 0);
    localparam bit has_folw  = (index < n_stages - 1);
    localparam bit odd_index = ((index % 2) == 1);

    logic shift;
    logic exchange;
    logic shift_in_valid;
    logic as_lower;
    logic as_upper;
    logic trade_prev;
    logic trade_folw;
    logic swap_prev;
    logic swap_folw;

    assign shift    = shift_valid || (command == replica_pkg::cmd_drain);
    assign exchange = (command == replica_pkg::cmd_exchange);

    // a drain pulls an empty slot into the head
    assign shift_in_valid = (command == replica_pkg::cmd_drain && index == 0) ? 1'b0 : prev_valid;

    // a pair takes part when the parity of its lower index equals the phase
    assign as_lower = has_folw && (phase == odd_index);
    assign as_upper = has_prev && (phase != odd_index);

    replica_order order_prev (
        .mode      (mode),
        .opt       (opt),
        .low_data  (prev_data),
        .high_data (out_data),
        .trade     (trade_prev)
    );

    replica_order order_folw (
        .mode      (mode),
        .opt       (opt),
        .low_data  (out_data),
        .high_data (folw_data),
        .trade     (trade_folw)
    );

    // both members of a pair see the same decision, so the words cross exactly
    assign swap_prev = exchange && as_upper && prev_valid && out_valid && trade_prev;
    assign swap_folw = exchange && as_lower && folw_valid && out_valid && trade_folw;

    // an exchange only moves words between full slots, so valid holds
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (command == replica_pkg::cmd_clear) begin
            out_valid <= 1'b0;
        end else if (shift) begin
            out_valid <= shift_in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (shift) begin
            out_data <= prev_data;
        end else if (swap_folw) begin
            out_data <= folw_data;
        end else if (swap_prev) begin
            out_data <= prev_data;
        end
    end

    a_valid_known: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(out_valid)
    ) else $error("stage %0d valid is unknown", index);

endmodule

`default_nettype wire

/* replica_tb.sv */
`default_nettype none

module replica_tb;

    localparam int n_stages = 8;
    // operations issued over all tests, the phase alignment clears included
    localparam int test_ops = 175;

    logic                          clk;
    logic                          reset;
    replica_pkg::replica_command_t command;
    replica_pkg::opt_mode_t        opt_com;
    logic [6:0]                    K;
    logic [6:0]                    L;
    logic                          ordering_in_valid;
    replica_pkg::replica_word_t    ordering_in_data;
    logic                          ordering_out_valid;
    replica_pkg::replica_word_t    ordering_out_data;

    // slot 0 of the reference model is the head of the chain
    replica_pkg::replica_word_t model_word [n_stages];
    logic [n_stages-1:0]        model_valid;
    logic                       model_phase;
    replica_pkg::opt_mode_t     model_mode;
    logic [6:0]                 model_k;
    logic [6:0]                 model_l;

    replica_pkg::replica_word_t exp_q [$];
    replica_pkg::replica_word_t seen_q [$];
    replica_pkg::replica_word_t pushed_q [$];
    string                      test_name;
    int                         seen_count;
    int                         expected_count;
    int                         mismatch_errors;
    int                         count_errors;
    int                         other_errors;
    logic [15:0]                lfsr_state;
    logic [13:0]                thresholds [3];

    replica_top #(
        .n_stages (n_stages)
    ) dut0 (
        .clk                (clk),
        .reset              (reset),
        .command            (command),
        .opt_com            (opt_com),
        .K                  (K),
        .L                  (L),
        .ordering_in_valid  (ordering_in_valid),
        .ordering_in_data   (ordering_in_data),
        .ordering_out_valid (ordering_out_valid),
        .ordering_out_data  (ordering_out_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic replica_pkg::replica_word_t random_word();
        logic [8*7-1:0] bits;
        for (int i = 0; i < 8 * 7; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits[i] = lfsr_state[0];
        end
        return bits;
    endfunction

    // words are kept in port lane order, so internal lane n is port lane 7-n
    function automatic logic model_trade(input replica_pkg::opt_mode_t mode,
                                         input logic [6:0] k, input logic [6:0] l,
                                         input replica_pkg::replica_word_t low,
                                         input replica_pkg::replica_word_t high);
        int pl;
        int sl;
        int lo0;
        int hi0;
        pl  = replica_pkg::lanes - 1 - int'(k[2:0]);
        sl  = replica_pkg::lanes - 1 - int'(l[2:0]);
        lo0 = int'(low[replica_pkg::lanes-1]);
        hi0 = int'(high[replica_pkg::lanes-1]);
        if (mode == replica_pkg::opt_threshold) begin
            return (lo0 - hi0) > int'({k, l});
        end else if (low[pl] != high[pl]) begin
            return low[pl] > high[pl];
        end else begin
            return low[sl] > high[sl];
        end
    endfunction

    function automatic void model_shift(input logic valid, input replica_pkg::replica_word_t word);
        if (model_valid[n_stages-1]) begin
            exp_q.push_back(model_word[n_stages-1]);
            expected_count++;
        end
        for (int i = n_stages - 1; i > 0; i--) begin
            model_word[i]  = model_word[i-1];
            model_valid[i] = model_valid[i-1];
        end
        model_word[0]  = word;
        model_valid[0] = valid;
    endfunction

    function automatic void model_apply(input replica_pkg::replica_command_t op,
                                        input logic push,
                                        input replica_pkg::replica_word_t word);
        replica_pkg::replica_word_t tmp;
        if (push) begin
            model_shift(1'b1, word);
        end else begin
            if (op != replica_pkg::cmd_none) begin
                model_phase = ~model_phase;
            end
            case (op)
                replica_pkg::cmd_exchange: begin
                    for (int i = 0; i < n_stages - 1; i++) begin
                        if (((i % 2 == 1) == model_phase) && model_valid[i] &&
                            model_valid[i+1] &&
                            model_trade(model_mode, model_k, model_l,
                                        model_word[i], model_word[i+1])) begin
                            tmp             = model_word[i];
                            model_word[i]   = model_word[i+1];
                            model_word[i+1] = tmp;
                        end
                    end
                end
                replica_pkg::cmd_drain: model_shift(1'b0, '0);
                replica_pkg::cmd_clear: model_valid = '0;
                default: ;
            endcase
        end
    endfunction

    task automatic check_word(input string name, input replica_pkg::replica_word_t expected,
                              input replica_pkg::replica_word_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            mismatch_errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("MISMATCH %s output count expected %0d actual %0d", name, expected, actual);
            count_errors++;
        end
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!reset && ordering_out_valid) begin
            seen_count++;
            seen_q.push_back(ordering_out_data);
            if (exp_q.size() == 0) begin
                $display("%s: output %h arrived while no output was expected",
                         test_name, ordering_out_data);
                other_errors++;
            end else begin
                check_word(test_name, exp_q.pop_front(), ordering_out_data);
            end
        end
    end

    initial begin
        repeat (test_ops * 20 + 200) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Test FAILED");
        $finish;
    end

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            command           <= replica_pkg::cmd_none;
            ordering_in_valid <= 1'b0;
        end
    endtask

    task automatic push_words(input int n);
        replica_pkg::replica_word_t w;
        for (int i = 0; i < n; i++) begin
            w = random_word();
            @(posedge clk);
            ordering_in_valid <= 1'b1;
            ordering_in_data  <= w;
            command           <= replica_pkg::cmd_none;
            pushed_q.push_back(w);
            model_apply(replica_pkg::cmd_none, 1'b1, w);
        end
        // a command must not reach the stages together with the last push
        idle_cycles(4);
    endtask

    task automatic issue_command(input replica_pkg::replica_command_t cmd, input int n);
        repeat (n) begin
            @(posedge clk);
            command           <= cmd;
            ordering_in_valid <= 1'b0;
            model_apply(cmd, 1'b0, '0);
        end
    endtask

    task automatic set_option(input replica_pkg::opt_mode_t mode, input logic [6:0] k,
                              input logic [6:0] l);
        @(posedge clk);
        opt_com    <= mode;
        K          <= k;
        L          <= l;
        command    <= replica_pkg::cmd_none;
        model_mode = mode;
        model_k    = k;
        model_l    = l;
    endtask

    task automatic start_test(input string name);
        test_name      = name;
        seen_count     = 0;
        expected_count = 0;
        seen_q.delete();
        pushed_q.delete();
        $display("running %s", name);
    endtask

    task automatic finish_test();
        int waited;
        idle_cycles(4);
        waited = 0;
        while (exp_q.size() != 0 && waited < 40) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: timed out with %0d outputs still missing", test_name, exp_q.size());
            other_errors++;
            exp_q.delete();
        end
        check_count(test_name, expected_count, seen_count);
    endtask

    task automatic run_sort(input string name, input replica_pkg::opt_mode_t mode,
                            input logic [6:0] k, input logic [6:0] l);
        start_test(name);
        set_option(mode, k, l);
        issue_command(replica_pkg::cmd_clear, 1);
        push_words(n_stages);
        issue_command(replica_pkg::cmd_exchange, n_stages);
        issue_command(replica_pkg::cmd_drain, n_stages);
        finish_test();
    endtask

    // with odd_pairs set the pass works on pairs (1,2), (3,4) and so on
    task automatic phase_pass(input string name, input logic odd_pairs);
        start_test(name);
        issue_command(replica_pkg::cmd_clear, 1);
        if (model_phase != !odd_pairs) begin
            issue_command(replica_pkg::cmd_clear, 1);
        end
        push_words(n_stages);
        issue_command(replica_pkg::cmd_exchange, 1);
        issue_command(replica_pkg::cmd_drain, n_stages);
        finish_test();
    endtask

    initial begin
        reset             = 1'b1;
        command           = replica_pkg::cmd_none;
        opt_com           = replica_pkg::opt_keyed;
        K                 = '0;
        L                 = '0;
        ordering_in_valid = 1'b0;
        ordering_in_data  = '0;
        lfsr_state        = 16'd47098;
        model_valid       = '0;
        model_phase       = 1'b0;
        model_mode        = replica_pkg::opt_keyed;
        model_k           = '0;
        model_l           = '0;
        mismatch_errors   = 0;
        count_errors      = 0;
        other_errors      = 0;
        thresholds[0]     = 14'd0;
        thresholds[1]     = 14'd20;
        thresholds[2]     = 14'd16383;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        start_test("reset");
        repeat (8) begin
            @(negedge clk);
            if (ordering_out_valid !== 1'b0) begin
                $display("reset: ordering_out_valid is not low after reset");
                other_errors++;
            end
        end
        finish_test();

        start_test("order without exchange");
        push_words(12);
        finish_test();
        issue_command(replica_pkg::cmd_drain, n_stages);
        finish_test();

        run_sort("keyed sort", replica_pkg::opt_keyed, 7'd2, 7'd5);
        for (int j = 0; j + 1 < seen_q.size(); j++) begin
            if (model_trade(replica_pkg::opt_keyed, 7'd2, 7'd5, seen_q[j+1], seen_q[j])) begin
                $display("keyed sort: drained words are out of order at output %0d", j + 1);
                other_errors++;
            end
        end

        for (int t = 0; t < 3; t++) begin
            run_sort($sformatf("threshold %0d", thresholds[t]), replica_pkg::opt_threshold,
                     thresholds[t][13:7], thresholds[t][6:0]);
        end
        // nothing can exceed the largest threshold, so the push order survives
        for (int j = 0; j < seen_q.size() && j < pushed_q.size(); j++) begin
            check_word(test_name, pushed_q[j], seen_q[j]);
        end

        set_option(replica_pkg::opt_keyed, 7'd2, 7'd5);
        phase_pass("odd phase pass", 1'b1);
        phase_pass("even phase pass", 1'b0);

        start_test("clear");
        push_words(n_stages);
        issue_command(replica_pkg::cmd_clear, 1);
        issue_command(replica_pkg::cmd_drain, n_stages);
        finish_test();
        check_count(test_name, 0, seen_count);

        $display("errors: %0d mismatch, %0d count, %0d other",
                 mismatch_errors, count_errors, other_errors);
        if (mismatch_errors + count_errors + other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* replica_top.sv */
`default_nettype none

module replica_top #(
    parameter int n_stages = 8
) (
    input  logic                          clk,
    input  logic                          reset,
    input  replica_pkg::replica_command_t command,
    input  replica_pkg::opt_mode_t        opt_com,
    input  logic [6:0]                    K,
    input  logic [6:0]                    L,
    input  logic                          ordering_in_valid,
    input  replica_pkg::replica_word_t    ordering_in_data,
    output logic                          ordering_out_valid,
    output replica_pkg::replica_word_t    ordering_out_data
);

    replica_pkg::opt_u             opt;
    logic                          aligned_valid;
    replica_pkg::replica_word_t    aligned_data;
    replica_pkg::replica_command_t command_q;
    logic                          phase;
    logic                          tail_shift;

    // slot 0 is the aligned input, slot n_stages+1 is the empty neighbour of the tail
    logic                       [n_stages+1:0] chain_valid;
    replica_pkg::replica_word_t [n_stages+1:0] chain_data;

    // K lands in the upper half and L in the lower half for either view
    always_comb begin
        opt.keys.primary   = K;
        opt.keys.secondary = L;
    end

    replica_ctrl ctrl0 (
        .clk           (clk),
        .reset         (reset),
        .command       (command),
        .in_valid      (ordering_in_valid),
        .in_data       (ordering_in_data),
        .aligned_valid (aligned_valid),
        .aligned_data  (aligned_data),
        .command_q     (command_q),
        .phase         (phase)
    );

    assign chain_valid[0]          = aligned_valid;
    assign chain_data[0]           = aligned_data;
    assign chain_valid[n_stages+1] = 1'b0;
    assign chain_data[n_stages+1]  = '0;

    for (genvar g = 0; g < n_stages; g++) begin : g_stage
        replica_stage #(
            .n_stages (n_stages),
            .index    (g)
        ) stage (
            .clk         (clk),
            .reset       (reset),
            .command     (command_q),
            .mode        (opt_com),
            .opt         (opt),
            .phase       (phase),
            .shift_valid (aligned_valid),
            .prev_valid  (chain_valid[g]),
            .prev_data   (chain_data[g]),
            .folw_valid  (chain_valid[g+2]),
            .folw_data   (chain_data[g+2]),
            .out_valid   (chain_valid[g+1]),
            .out_data    (chain_data[g+1])
        );
    end

    // the tail word leaves on the same edge at which the chain shifts
    assign tail_shift = aligned_valid || (command_q == replica_pkg::cmd_drain);

    always_ff @(posedge clk) begin
        if (reset) begin
            ordering_out_valid <= 1'b0;
        end else begin
            ordering_out_valid <= tail_shift && chain_valid[n_stages];
        end
    end

    // lanes go back to port order on the way out
    always_ff @(posedge clk) begin
        for (int i = 0; i < replica_pkg::lanes; i++) begin
            ordering_out_data[i] <= chain_data[n_stages][replica_pkg::lanes-1-i];
        end
    end

endmodule

`default_nettype wire
